//--- verilog/cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;  // One data or instruction word
  typedef logic [31:0] addr_t;  // Byte address before or after mapping
  typedef logic [4:0] reg_idx_t;  // General register number

  typedef enum logic [2:0] {
    fetch_req,   // Fetch address is offered to the instruction cache
    fetch_wait,  // Core waits for the instruction word
    execute,     // Decode and compute the result
    mem_req,     // Load or store is offered to the data bus
    mem_wait,    // Core waits for the data bus to answer
    writeback    // Register write and pc update happen here
  } core_state_t;

  // Primary opcodes live in bits 31 to 26 of the instruction
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j = 6'h02;
  localparam logic [5:0] op_beq = 6'h04;
  localparam logic [5:0] op_bne = 6'h05;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_ori = 6'h0d;
  localparam logic [5:0] op_lui = 6'h0f;
  localparam logic [5:0] op_lw = 6'h23;
  localparam logic [5:0] op_sw = 6'h2b;

  localparam logic [5:0] fn_addu = 6'h21;  // Function field of ADDU under op_special

  localparam addr_t reset_pc = 32'hbfc0_0000;  // Boot vector sits in kseg1

  // Top three address bits select the segment
  localparam logic [2:0] seg_cached = 3'b100;  // kseg0 starts at 0x8000_0000
  localparam logic [2:0] seg_uncached = 3'b101;  // kseg1 starts at 0xa000_0000

  localparam int icache_lines = 16;  // One word per line
  localparam int icache_index_bits = 4;  // Enough to pick one of the lines
  localparam int icache_tag_bits = 32 - icache_index_bits - 2;  // Rest above the index

  localparam logic [1:0] size_word = 2'd2;  // Bus size code for a 4 byte access

endpackage

//--- verilog/regfile.sv
module regfile import cpu_pkg::*; (
  input  logic     clk,
  input  reg_idx_t raddr_a,
  input  reg_idx_t raddr_b,
  output word_t    rdata_a,
  output word_t    rdata_b,
  input  logic     we,
  input  reg_idx_t waddr,
  input  word_t    wdata
);

  word_t regs [0:31];  // Entry 0 is never written

  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin
      regs[waddr] <= wdata;  // Writes to register 0 fall away
    end
  end

  // Reads are combinational and register 0 always returns zero
  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- verilog/icache.sv
module icache import cpu_pkg::*; (
  input  logic  clk,
  input  logic  reset,

  input  logic  cpu_req,
  input  addr_t cpu_addr,
  input  logic  cpu_cached,
  output logic  cpu_addr_ok,
  output logic  cpu_data_ok,
  output word_t cpu_rdata,

  output logic  mem_req,
  output addr_t mem_addr,
  input  word_t mem_rdata,
  input  logic  mem_addr_ok,
  input  logic  mem_data_ok
);

  typedef enum logic [1:0] {
    idle,       // Ready for a new fetch
    miss_req,   // Fetch is offered to memory
    miss_wait,  // Memory is producing the word
    respond     // Word goes back to the core
  } cache_state_t;

  typedef logic [icache_index_bits-1:0] index_t;
  typedef logic [icache_tag_bits-1:0] tag_t;

  cache_state_t state, state_next;
  logic [icache_lines-1:0] valid;  // One valid bit per line
  tag_t  tags  [icache_lines];
  word_t lines [icache_lines];

  index_t req_index, fill_index;
  tag_t   req_tag, fill_tag;
  logic   hit;
  addr_t  addr_q;  // Address of the accepted fetch
  logic   cached_q;  // Fetch may fill its line
  word_t  rdata_q;  // Word waiting to go back to the core

  assign req_index = cpu_addr[2 +: icache_index_bits];  // Byte offset bits are skipped
  assign req_tag = cpu_addr[31 -: icache_tag_bits];
  assign fill_index = addr_q[2 +: icache_index_bits];
  assign fill_tag = addr_q[31 -: icache_tag_bits];

  // Uncached fetches never count as hits so they always go to memory
  assign hit = cpu_cached && valid[req_index] && (tags[req_index] == req_tag);

  assign cpu_addr_ok = (state == idle) && cpu_req;  // Hits and misses are both taken at once
  assign cpu_data_ok = (state == respond);
  assign cpu_rdata = rdata_q;

  assign mem_req = (state == miss_req);
  assign mem_addr = addr_q;

  always_comb begin
    state_next = state;
    case (state)
      idle:      if (cpu_req) state_next = hit ? respond : miss_req;
      miss_req:  if (mem_addr_ok) state_next = miss_wait;
      miss_wait: if (mem_data_ok) state_next = respond;
      respond:   state_next = idle;
      default:   state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      valid <= '0;  // Every line starts empty
    end else begin
      state <= state_next;
      if (state == miss_wait && mem_data_ok && cached_q) begin
        valid[fill_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_addr_ok) begin
      addr_q <= cpu_addr;
      cached_q <= cpu_cached;
      rdata_q <= lines[req_index];  // Only used when the lookup hit
    end
    if (state == miss_wait && mem_data_ok) begin
      rdata_q <= mem_rdata;
      if (cached_q) begin
        tags[fill_index] <= fill_tag;  // Refill replaces whatever the line held
        lines[fill_index] <= mem_rdata;
      end
    end
  end

endmodule

//--- verilog/mini_core.sv
module mini_core import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  output logic       inst_req,
  output addr_t      inst_addr,
  output logic       inst_cached,
  input  word_t      inst_rdata,
  input  logic       inst_addr_ok,
  input  logic       inst_data_ok,

  output logic       data_req,
  output logic       data_wr,
  output logic [1:0] data_size,
  output addr_t      data_addr,
  output word_t      data_wdata,
  input  word_t      data_rdata,
  input  logic       data_addr_ok,
  input  logic       data_data_ok,

  output addr_t      debug_wb_pc,
  output logic [3:0] debug_wb_rf_wen,
  output reg_idx_t   debug_wb_rf_wnum,
  output word_t      debug_wb_rf_wdata
);

  core_state_t state, state_next;
  addr_t       pc;  // Address of the instruction in flight
  word_t       ir;  // Instruction held from fetch until writeback
  word_t       result;  // Value that writeback puts in the register file

  logic [5:0]  opcode;
  logic [5:0]  funct;
  reg_idx_t    rs, rt, rd;
  logic [15:0] imm;
  word_t       imm_sext, imm_zext;
  word_t       rs_val, rt_val;
  word_t       alu_out;
  addr_t       pc_plus4, branch_target, jump_target, pc_next;
  logic        is_mem;
  logic        writes_reg;
  reg_idx_t    dst;
  logic        rf_we;
  logic [2:0]  pc_seg;

  // kseg0 and kseg1 alias the same low 512 MB of physical space
  function automatic addr_t to_phys(addr_t vaddr);
    return {3'b000, vaddr[28:0]};
  endfunction

  assign opcode = ir[31:26];
  assign rs = ir[25:21];
  assign rt = ir[20:16];
  assign rd = ir[15:11];
  assign imm = ir[15:0];
  assign funct = ir[5:0];
  assign imm_sext = {{16{imm[15]}}, imm};  // ADDIU, loads, stores and branches
  assign imm_zext = {16'b0, imm};  // ORI takes the immediate unsigned

  regfile rf (
    .clk     (clk),
    .raddr_a (rs),
    .raddr_b (rt),
    .rdata_a (rs_val),
    .rdata_b (rt_val),
    .we      (rf_we),
    .waddr   (dst),
    .wdata   (result)
  );

  always_comb begin
    alu_out = rs_val + imm_sext;  // ADDIU sum and also the load or store address
    case (opcode)
      op_special: alu_out = rs_val + rt_val;  // Only ADDU is decoded under special
      op_lui:     alu_out = {imm, 16'b0};
      op_ori:     alu_out = rs_val | imm_zext;
      default:    ;
    endcase
  end

  always_comb begin
    writes_reg = 1'b0;
    dst = rt;  // Immediate forms write rt
    case (opcode)
      op_special: begin
        writes_reg = (funct == fn_addu);  // Other function codes act as no-ops
        dst = rd;
      end
      op_addiu, op_lui, op_ori, op_lw: writes_reg = 1'b1;
      default: ;
    endcase
  end

  assign is_mem = (opcode == op_lw) || (opcode == op_sw);

  // No delay slot so a taken branch goes straight to its target
  assign pc_plus4 = pc + 32'd4;
  assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
  assign jump_target = {pc_plus4[31:28], ir[25:0], 2'b00};

  always_comb begin
    pc_next = pc_plus4;
    case (opcode)
      op_beq:  if (rs_val == rt_val) pc_next = branch_target;
      op_bne:  if (rs_val != rt_val) pc_next = branch_target;
      op_j:    pc_next = jump_target;
      default: ;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      fetch_req:  if (inst_addr_ok) state_next = fetch_wait;  // Hold the request until taken
      fetch_wait: if (inst_data_ok) state_next = execute;
      execute:    state_next = is_mem ? mem_req : writeback;
      mem_req:    if (data_addr_ok) state_next = mem_wait;
      mem_wait:   if (data_data_ok) state_next = writeback;
      writeback:  state_next = fetch_req;
      default:    state_next = fetch_req;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fetch_req;
      pc <= reset_pc;
    end else begin
      state <= state_next;
      if (state == writeback) pc <= pc_next;  // Register values read here are still the old ones
    end
  end

  always_ff @(posedge clk) begin
    if (state == fetch_wait && inst_data_ok) ir <= inst_rdata;
    if (state == execute) result <= alu_out;
    if (state == mem_wait && data_data_ok && opcode == op_lw) result <= data_rdata;  // Load data
  end

  assign pc_seg = pc[31:29];

  always_comb begin
    case (pc_seg)
      seg_cached:   inst_cached = 1'b1;
      seg_uncached: inst_cached = 1'b0;
      default:      inst_cached = 1'b0;  // Mapped segments have no TLB and stay uncached
    endcase
  end

  assign inst_req = (state == fetch_req);
  assign inst_addr = to_phys(pc);

  assign data_req = (state == mem_req);
  assign data_wr = (state == mem_req) && (opcode == op_sw);
  assign data_size = size_word;  // Only word accesses exist
  assign data_addr = to_phys(alu_out);
  assign data_wdata = rt_val;  // SW stores rt

  assign rf_we = (state == writeback) && writes_reg;

  // Trace shows a write only when a real register changes
  assign debug_wb_pc = pc;
  assign debug_wb_rf_wen = (rf_we && dst != '0) ? 4'hf : 4'h0;
  assign debug_wb_rf_wnum = dst;
  assign debug_wb_rf_wdata = result;

endmodule

//--- verilog/mycpu.sv
module mycpu import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  // Instruction bus toward memory
  output logic       inst_req,
  output logic       inst_wr,
  output logic [1:0] inst_size,
  output addr_t      inst_addr,
  input  word_t      inst_rdata,
  input  logic       inst_addr_ok,
  input  logic       inst_data_ok,

  // Data bus toward memory
  output logic       data_req,
  output logic       data_wr,
  output logic [1:0] data_size,
  output addr_t      data_addr,
  output word_t      data_wdata,
  input  word_t      data_rdata,
  input  logic       data_addr_ok,
  input  logic       data_data_ok,

  // Writeback trace
  output addr_t      debug_wb_pc,
  output logic [3:0] debug_wb_rf_wen,
  output reg_idx_t   debug_wb_rf_wnum,
  output word_t      debug_wb_rf_wdata
);

  logic  core_inst_req;  // Fetch request from the core to the cache
  addr_t core_inst_addr;  // Physical fetch address
  logic  core_inst_cached;  // High when the fetch comes from kseg0
  word_t core_inst_rdata;  // Instruction word back from the cache
  logic  core_inst_addr_ok;  // Cache took the fetch
  logic  core_inst_data_ok;  // Cache returns the word

  assign inst_wr = 1'b0;  // Instruction bus only reads
  assign inst_size = size_word;  // Every fetch is a full word

  mini_core core (
    .clk               (clk),
    .reset             (reset),
    .inst_req          (core_inst_req),
    .inst_addr         (core_inst_addr),
    .inst_cached       (core_inst_cached),
    .inst_rdata        (core_inst_rdata),
    .inst_addr_ok      (core_inst_addr_ok),
    .inst_data_ok      (core_inst_data_ok),
    .data_req          (data_req),  // Data bus goes out without a cache
    .data_wr           (data_wr),
    .data_size         (data_size),
    .data_addr         (data_addr),
    .data_wdata        (data_wdata),
    .data_rdata        (data_rdata),
    .data_addr_ok      (data_addr_ok),
    .data_data_ok      (data_data_ok),
    .debug_wb_pc       (debug_wb_pc),
    .debug_wb_rf_wen   (debug_wb_rf_wen),
    .debug_wb_rf_wnum  (debug_wb_rf_wnum),
    .debug_wb_rf_wdata (debug_wb_rf_wdata)
  );

  icache icache (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (core_inst_req),
    .cpu_addr    (core_inst_addr),
    .cpu_cached  (core_inst_cached),
    .cpu_addr_ok (core_inst_addr_ok),
    .cpu_data_ok (core_inst_data_ok),
    .cpu_rdata   (core_inst_rdata),
    .mem_req     (inst_req),
    .mem_addr    (inst_addr),
    .mem_rdata   (inst_rdata),
    .mem_addr_ok (inst_addr_ok),
    .mem_data_ok (inst_data_ok)
  );

endmodule

//--- bench/sram_like_mem.sv
module sram_like_mem import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       req,
  input  logic       wr,
  input  addr_t      addr,
  input  word_t      wdata,
  output word_t      rdata,
  output logic       addr_ok,
  output logic       data_ok,
  output int         req_count
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int slots = 64;  // Words the sparse store can hold

  addr_t       keys [slots];  // Physical address of each stored word
  word_t       words [slots];
  int          used = 0;  // Filled slots
  int unsigned lcg_state = 5;
  logic        armed = 1'b0;  // Delay already chosen for the waiting request
  logic        pending = 1'b0;  // Request taken and not answered yet
  int          gap = 0;  // Cycles left before the next handshake step
  addr_t       held_addr;

  initial begin
    rdata = '0;
    addr_ok = 1'b0;
    data_ok = 1'b0;
    req_count = 0;
  end

  function automatic int find_slot(addr_t a);
    int idx;
    idx = -1;
    for (int i = 0; i < used; i++) begin
      if (keys[i] == a) idx = i;
    end
    return idx;
  endfunction

  function automatic word_t read_word(addr_t a);
    int idx;
    idx = find_slot(a);
    if (idx < 0) return {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;  // Empty words echo their address
    return words[idx];
  endfunction

  task automatic store_word(addr_t a, word_t d);
    int idx;
    idx = find_slot(a);
    if (idx < 0 && used < slots) begin
      idx = used;  // New address takes the next free slot
      keys[idx] = a;
      used = used + 1;
    end
    if (idx >= 0) words[idx] = d;
  endtask

  function automatic int next_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'((lcg_state >> 16) % 4);  // Upper bits give zero to three cycles
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      addr_ok <= 1'b0;
      data_ok <= 1'b0;
      req_count <= 0;
      armed = 1'b0;
      pending = 1'b0;
    end else begin
      data_ok <= 1'b0;  // Answer lasts one cycle
      if (!pending && req) begin
        if (addr_ok) begin
          addr_ok <= 1'b0;  // Handshake completes on this edge
          req_count <= req_count + 1;
          armed = 1'b0;
          pending = 1'b1;
          held_addr = addr;
          if (wr) store_word(addr, wdata);
          gap = next_delay();
        end else begin
          if (!armed) begin
            gap = next_delay();
            armed = 1'b1;
          end
          if (gap == 0) addr_ok <= 1'b1;
          else gap = gap - 1;
        end
      end
      if (pending) begin
        if (gap == 0) begin
          data_ok <= 1'b1;
          rdata <= read_word(held_addr);  // Stores read back what they just wrote
          pending = 1'b0;
        end else begin
          gap = gap - 1;
        end
      end
    end
  end

endmodule

//--- bench/tb_mycpu.sv
module tb_mycpu import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam addr_t boot_phys = 32'h1fc0_0000;  // Boot vector with the segment bits cleared
  localparam int cycles_per_entry = 64;

  logic       clk;
  logic       reset;
  logic       inst_req;
  logic       inst_wr;
  logic [1:0] inst_size;
  addr_t      inst_addr;
  word_t      inst_rdata;
  logic       inst_addr_ok;
  logic       inst_data_ok;
  logic       data_req;
  logic       data_wr;
  logic [1:0] data_size;
  addr_t      data_addr;
  word_t      data_wdata;
  word_t      data_rdata;
  logic       data_addr_ok;
  logic       data_data_ok;
  addr_t      debug_wb_pc;
  logic [3:0] debug_wb_rf_wen;
  reg_idx_t   debug_wb_rf_wnum;
  word_t      debug_wb_rf_wdata;
  int         inst_count;  // Accepted instruction-bus requests

  addr_t    exp_pc [$];  // Expected trace in program order
  reg_idx_t exp_wnum [$];
  word_t    exp_wdata [$];
  int       expected_fetches;
  int       entries;
  logic     running;  // Monitor is active once reset has been checked
  logic     trace_done;
  logic     first_fetch_seen;
  addr_t    last_fetch_addr;  // Physical address of the latest instruction-bus request

  mycpu dut0 (.*);

  sram_like_mem imem (
    .clk       (clk),
    .reset     (reset),
    .req       (inst_req),
    .wr        (inst_wr),
    .addr      (inst_addr),
    .wdata     (32'h0),  // Instruction bus never writes
    .rdata     (inst_rdata),
    .addr_ok   (inst_addr_ok),
    .data_ok   (inst_data_ok),
    .req_count (inst_count)
  );

  sram_like_mem dmem (
    .clk       (clk),
    .reset     (reset),
    .req       (data_req),
    .wr        (data_wr),
    .addr      (data_addr),
    .wdata     (data_wdata),
    .rdata     (data_rdata),
    .addr_ok   (data_addr_ok),
    .data_ok   (data_data_ok),
    .req_count ()
  );

  always #4 clk = ~clk;  // 8 ns period

  task automatic stop_with_failure();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t %s got %08h expected %08h", $time, name, got, expected);
      stop_with_failure();
    end
  endtask

  task automatic read_testdata();
    int    fd;
    int    fields;
    string line;
    byte   tag;
    word_t a;
    word_t b;
    word_t c;
    fd = $fopen("bench/testdata_prog.txt", "r");
    if (fd == 0) begin
      $display("Cannot open bench/testdata_prog.txt for reading");
      stop_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      tag = line[0];  // First character names the record kind
      case (tag)
        "m": begin
          fields = $sscanf(line, "m %h %h", a, b);
          if (fields != 2) begin
            $display("Program line in the data file is malformed: %s", line);
            stop_with_failure();
          end else begin
            imem.store_word(a, b);  // Both models start from one image
            dmem.store_word(a, b);
          end
        end
        "t": begin
          fields = $sscanf(line, "t %h %h %h", a, b, c);
          if (fields != 3) begin
            $display("Trace line in the data file is malformed: %s", line);
            stop_with_failure();
          end else begin
            exp_pc.push_back(a);
            exp_wnum.push_back(b[4:0]);
            exp_wdata.push_back(c);
          end
        end
        "c": begin
          fields = $sscanf(line, "c %d", expected_fetches);
          if (fields != 1) begin
            $display("Fetch count line in the data file is malformed: %s", line);
            stop_with_failure();
          end
        end
        default: ;  // Comments and blank lines
      endcase
    end
    $fclose(fd);
  endtask

  task automatic check_quiet_outputs();
    check_value("inst_req", inst_req, 1'b0);
    check_value("data_req", data_req, 1'b0);
    check_value("data_wr", data_wr, 1'b0);
    check_value("debug_wb_rf_wen", debug_wb_rf_wen, 4'h0);
  endtask

  task automatic check_trace_entry();
    addr_t    pc_exp;
    reg_idx_t wnum_exp;
    word_t    wdata_exp;
    if (exp_pc.size() == 0) begin
      $display("Register write at pc %08h came after the last expected entry", debug_wb_pc);
      stop_with_failure();
    end else begin
      pc_exp = exp_pc.pop_front();
      wnum_exp = exp_wnum.pop_front();
      wdata_exp = exp_wdata.pop_front();
      check_value("debug_wb_rf_wen", debug_wb_rf_wen, 4'hf);
      check_value("debug_wb_pc", debug_wb_pc, pc_exp);
      check_value("debug_wb_rf_wnum", debug_wb_rf_wnum, wnum_exp);
      check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, wdata_exp);
      // An uncached fetch is the latest bus request before its own writeback
      if (pc_exp[31:29] == seg_uncached) begin
        check_value("inst_addr", last_fetch_addr, {3'b000, pc_exp[28:0]});
      end
      if (exp_pc.size() == 0) begin
        check_value("inst_req_count", inst_count, expected_fetches);  // Second pass adds none
        trace_done = 1'b1;
      end
    end
  endtask

  // Both buses and the trace are sampled on every rising edge
  always @(posedge clk) begin
    if (running) begin
      if (inst_req && inst_addr_ok) begin
        if (!first_fetch_seen) check_value("inst_addr", inst_addr, boot_phys);
        check_value("inst_wr", inst_wr, 1'b0);
        check_value("inst_size", inst_size, 2'd2);  // Fetches are always whole words
        last_fetch_addr = inst_addr;
        first_fetch_seen = 1'b1;
      end
      if (data_req && data_addr_ok) check_value("data_size", data_size, 2'd2);
      if (debug_wb_rf_wen != 4'h0) check_trace_entry();
    end
  end

  initial begin
    int cycles;
    int limit;
    clk = 1'b0;
    reset = 1'b1;
    running = 1'b0;
    trace_done = 1'b0;
    first_fetch_seen = 1'b0;
    last_fetch_addr = '0;
    expected_fetches = 0;
    read_testdata();
    entries = exp_pc.size();
    limit = cycles_per_entry * entries;  // Budget grows with the program
    @(posedge clk);  // First edge loads the reset state
    repeat (4) begin
      @(posedge clk);
      check_quiet_outputs();
    end
    reset <= 1'b0;
    @(posedge clk);
    check_quiet_outputs();  // Cycle right after reset drops
    running = 1'b1;
    cycles = 0;
    while (!trace_done && cycles < limit) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    if (!trace_done) begin
      $display("Program did not finish in %0d cycles, %0d of %0d trace entries left",
               limit, exp_pc.size(), entries);
      stop_with_failure();
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- vlog.f
verilog/cpu_pkg.sv
verilog/regfile.sv
verilog/icache.sv
verilog/mini_core.sv
verilog/mycpu.sv
bench/sram_like_mem.sv
bench/tb_mycpu.sv

//--- bench/testdata_prog.txt
# m <phys addr> <word> is a program word, t <virtual pc> <wnum> <wdata> is an expected write
# c <count> gives the instruction-bus requests made up to the last expected write
m 1fc00000 3c08a000  lui   r8, 0xa000
m 1fc00004 35081000  ori   r8, r8, 0x1000
m 1fc00008 24090002  addiu r9, r0, 2
m 1fc0000c 240a0011  addiu r10, r0, 0x11
m 1fc00010 08000000  j     0xb0000000
m 10000000 1000fffd  beq   r0, r0, 0xaffffff8
m 0ffffff8 08000000  j     0xa0000000
m 00000000 1000ffdf  beq   r0, r0, 0x9fffff80
m 1fffff80 01495821  addu  r11, r10, r9
m 1fffff84 ad0b0000  sw    r11, 0(r8)
m 1fffff88 254a0022  addiu r10, r10, 0x22
m 1fffff8c 8d0c0000  lw    r12, 0(r8)
m 1fffff90 158bffff  bne   r12, r11, self
m 1fffff94 ad0a0004  sw    r10, 4(r8)
m 1fffff98 2529ffff  addiu r9, r9, -1
m 1fffff9c 8d0d0004  lw    r13, 4(r8)
m 1fffffa0 1520fff7  bne   r9, r0, 0x9fffff80
m 1fffffa4 11aa0001  beq   r13, r10, 0x9fffffac
m 1fffffa8 240e0bad  addiu r14, r0, 0xbad
m 1fffffac 35af5000  ori   r15, r13, 0x5000
m 1fffffb0 0bffffec  j     self
t bfc00000 08 a0000000
t bfc00004 08 a0001000
t bfc00008 09 00000002
t bfc0000c 0a 00000011
t 9fffff80 0b 00000013
t 9fffff88 0a 00000033
t 9fffff8c 0c 00000013
t 9fffff98 09 00000001
t 9fffff9c 0d 00000033
t 9fffff80 0b 00000034
t 9fffff88 0a 00000055
t 9fffff8c 0c 00000034
t 9fffff98 09 00000000
t 9fffff9c 0d 00000055
t 9fffffac 0f 00005055
c 19
